//--- common/mm_ram_pkg.sv
// address map, bus widths, bus and peripheral structs and read-select enum for mm_ram
package mm_ram_pkg;

    // widths
    localparam int RAM_ADDR_WIDTH    = 16;
    localparam int INSTR_RDATA_WIDTH = 128;

    typedef logic [RAM_ADDR_WIDTH-1:0]    ram_addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [3:0]                   be_t;
    typedef logic [INSTR_RDATA_WIDTH-1:0] instr_word_t;

    // pseudo-peripheral addresses
    localparam logic [31:0] PRINT_ADDR      = 32'h1000_0000;
    localparam logic [31:0] STATUS_ADDR     = 32'h2000_0000;
    localparam logic [31:0] EXIT_ADDR       = 32'h2000_0004;
    localparam logic [31:0] TIMER_MASK_ADDR = 32'h1500_0000;
    localparam logic [31:0] TIMER_CNT_ADDR  = 32'h1500_0004;

    // interrupt id that acknowledges the timer, also its bit in the mask
    localparam int TIMER_IRQ_ID = 7;

    localparam word_t TESTS_PASSED_CODE = 32'd123456789;
    localparam word_t TESTS_FAILED_CODE = 32'd1;

    // core instruction bus
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } instr_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        instr_word_t rdata;
    } instr_rsp_t;

    // core data bus
    typedef struct packed {
        logic        req;
        logic        we;
        be_t         be;
        logic [31:0] addr;
        word_t       wdata;
    } data_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } data_rsp_t;

    // decoded request towards the ram data port
    typedef struct packed {
        logic      en;
        logic      we;
        be_t       be;
        ram_addr_t addr;
        word_t     wdata;
    } ram_data_req_t;

    // one write strobe per peripheral register, shared write data
    typedef struct packed {
        logic  print_we;
        logic  status_we;
        logic  exit_we;
        logic  timer_mask_we;
        logic  timer_cnt_we;
        word_t wdata;
    } per_wr_t;

    typedef struct packed {
        logic       print_valid;
        logic [7:0] print_char;
        logic       tests_passed;
        logic       tests_failed;
        logic       exit_valid;
        word_t      exit_value;
    } host_status_t;

    // source of the data returned in the response cycle
    typedef enum logic {
        RSEL_RAM,
        RSEL_NONE
    } rsel_t;

endpackage

//--- dp_ram/dp_ram.sv
// dual-port byte-addressed ram with 128-bit instruction read port and byte-enabled data port
module dp_ram (
    input  logic                      clk_i,

    input  logic                      instr_en_i,
    input  mm_ram_pkg::ram_addr_t     instr_addr_i,
    output mm_ram_pkg::instr_word_t   instr_rdata_o,
    output logic                      instr_rvalid_o,

    input  mm_ram_pkg::ram_data_req_t data_req_i,
    output mm_ram_pkg::word_t         data_rdata_o
);
    import mm_ram_pkg::*;

    localparam int INSTR_BYTES = INSTR_RDATA_WIDTH / 8;

    logic [7:0] mem [2**RAM_ADDR_WIDTH];

    ram_addr_t instr_base;

    // fetches are aligned down to a 16-byte block
    assign instr_base = {instr_addr_i[RAM_ADDR_WIDTH-1:4], 4'b0000};

    // port a, lowest address lands in the lowest byte lane
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_base + ram_addr_t'(i)];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        instr_rvalid_o <= instr_en_i;
    end

    // port b, word access with byte enables on writes
    always_ff @(posedge clk_i) begin
        if (data_req_i.en) begin
            if (data_req_i.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (data_req_i.be[i]) begin
                        mem[data_req_i.addr + ram_addr_t'(i)] <= data_req_i.wdata[8*i +: 8];
                    end
                end
            end else begin
                for (int i = 0; i < 4; i++) begin
                    data_rdata_o[8*i +: 8] <= mem[data_req_i.addr + ram_addr_t'(i)];
                end
            end
        end
    end

endmodule

//--- source/data_decoder.sv
// data bus address decoder with ram and peripheral strobes and response mux
module data_decoder (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  mm_ram_pkg::data_req_t     data_req_i,
    input  mm_ram_pkg::word_t         ram_rdata_i,
    output mm_ram_pkg::ram_data_req_t ram_req_o,
    output mm_ram_pkg::per_wr_t       per_wr_o,
    output mm_ram_pkg::data_rsp_t     data_rsp_o
);
    import mm_ram_pkg::*;

    logic  in_ram;
    logic  wr_req;
    rsel_t rsel_d;
    rsel_t rsel_q;
    logic  rvalid_q;

    // ram occupies the bottom 64 KiB of the address space
    assign in_ram = (data_req_i.addr[31:RAM_ADDR_WIDTH] == '0);
    assign wr_req = data_req_i.req & data_req_i.we;

    always_comb begin
        ram_req_o.en    = data_req_i.req & in_ram;
        ram_req_o.we    = data_req_i.we;
        ram_req_o.be    = data_req_i.be;
        ram_req_o.addr  = {data_req_i.addr[RAM_ADDR_WIDTH-1:2], 2'b00};
        ram_req_o.wdata = data_req_i.wdata;
    end

    // at most one strobe fires, each peripheral has its own address
    always_comb begin
        per_wr_o.print_we      = wr_req & (data_req_i.addr == PRINT_ADDR);
        per_wr_o.status_we     = wr_req & (data_req_i.addr == STATUS_ADDR);
        per_wr_o.exit_we       = wr_req & (data_req_i.addr == EXIT_ADDR);
        per_wr_o.timer_mask_we = wr_req & (data_req_i.addr == TIMER_MASK_ADDR);
        per_wr_o.timer_cnt_we  = wr_req & (data_req_i.addr == TIMER_CNT_ADDR);
        per_wr_o.wdata         = data_req_i.wdata;
    end

    // only ram reads return data, writes and unmapped reads give zero
    always_comb begin
        if (data_req_i.req && !data_req_i.we && in_ram) begin
            rsel_d = RSEL_RAM;
        end else begin
            rsel_d = RSEL_NONE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsel_q   <= RSEL_NONE;
            rvalid_q <= 1'b0;
        end else begin
            rsel_q   <= rsel_d;
            rvalid_q <= data_req_i.req;
        end
    end

    always_comb begin
        data_rsp_o.gnt    = data_req_i.req;
        data_rsp_o.rvalid = rvalid_q;
        if (rsel_q == RSEL_RAM) begin
            data_rsp_o.rdata = ram_rdata_i;
        end else begin
            data_rsp_o.rdata = '0;
        end
    end

endmodule

//--- source/timer_irq.sv
// countdown timer with interrupt mask, timer interrupt and acknowledge by id
module timer_irq (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  mm_ram_pkg::per_wr_t per_wr_i,
    input  logic                irq_ack_i,
    input  logic [5:0]          irq_id_i,
    output logic                irq_timer_o
);
    import mm_ram_pkg::*;

    word_t mask_q;
    word_t cnt_q;
    logic  irq_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else begin
            if (per_wr_i.timer_mask_we) begin
                mask_q <= per_wr_i.wdata;
            end else if (per_wr_i.timer_cnt_we) begin
                cnt_q <= per_wr_i.wdata;
            end else begin
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end
                // the 1 to 0 transition requests the interrupt
                if (cnt_q == 32'd1 && mask_q[TIMER_IRQ_ID]) begin
                    irq_q <= 1'b1;
                end
            end
            // acknowledge wins over a new request in the same cycle
            if (irq_ack_i && irq_id_i == 6'(TIMER_IRQ_ID)) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_timer_o = irq_q;

endmodule

//--- source/host_port.sv
// host reporting registers for character output, test pass/fail and exit value
module host_port (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  mm_ram_pkg::per_wr_t      per_wr_i,
    output mm_ram_pkg::host_status_t host_status_o
);
    import mm_ram_pkg::*;

    logic       print_valid_q;
    logic       passed_q;
    logic       failed_q;
    logic       exit_valid_q;
    logic [7:0] print_char_q;
    word_t      exit_value_q;

    // single-cycle pulses, one cycle after the write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            print_valid_q <= 1'b0;
            passed_q      <= 1'b0;
            failed_q      <= 1'b0;
            exit_valid_q  <= 1'b0;
        end else begin
            print_valid_q <= per_wr_i.print_we;
            passed_q      <= per_wr_i.status_we && (per_wr_i.wdata == TESTS_PASSED_CODE);
            failed_q      <= per_wr_i.status_we && (per_wr_i.wdata == TESTS_FAILED_CODE);
            exit_valid_q  <= per_wr_i.exit_we;
        end
    end

    always_ff @(posedge clk_i) begin
        if (per_wr_i.print_we) begin
            print_char_q <= per_wr_i.wdata[7:0];
        end
        if (per_wr_i.exit_we) begin
            exit_value_q <= per_wr_i.wdata;
        end
    end

    assign host_status_o = '{print_valid: print_valid_q, print_char: print_char_q,
                             tests_passed: passed_q, tests_failed: failed_q,
                             exit_valid: exit_valid_q, exit_value: exit_value_q};

endmodule

//--- source/mm_ram_top.sv
// top level of the memory wrapper, connecting decoder, dual-port ram, timer and host port
module mm_ram_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  mm_ram_pkg::instr_req_t    instr_req_i,
    output mm_ram_pkg::instr_rsp_t    instr_rsp_o,

    input  mm_ram_pkg::data_req_t     data_req_i,
    output mm_ram_pkg::data_rsp_t     data_rsp_o,

    input  logic                      irq_ack_i,
    input  logic [5:0]                irq_id_i,
    output logic                      irq_timer_o,

    output mm_ram_pkg::host_status_t  host_status_o
);
    import mm_ram_pkg::*;

    ram_data_req_t ram_req;
    word_t         ram_rdata;
    per_wr_t       per_wr;
    instr_word_t   instr_rdata;
    logic          instr_rvalid;

    data_decoder u_data_decoder (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .data_req_i  (data_req_i),
        .ram_rdata_i (ram_rdata),
        .ram_req_o   (ram_req),
        .per_wr_o    (per_wr),
        .data_rsp_o  (data_rsp_o)
    );

    // instruction port is never stalled, so grant follows req directly
    dp_ram u_dp_ram (
        .clk_i          (clk_i),
        .instr_en_i     (instr_req_i.req),
        .instr_addr_i   (instr_req_i.addr[RAM_ADDR_WIDTH-1:0]),
        .instr_rdata_o  (instr_rdata),
        .instr_rvalid_o (instr_rvalid),
        .data_req_i     (ram_req),
        .data_rdata_o   (ram_rdata)
    );

    assign instr_rsp_o = '{gnt: instr_req_i.req, rvalid: instr_rvalid, rdata: instr_rdata};

    timer_irq u_timer_irq (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .per_wr_i    (per_wr),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i),
        .irq_timer_o (irq_timer_o)
    );

    host_port u_host_port (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .per_wr_i      (per_wr),
        .host_status_o (host_status_o)
    );

endmodule

//--- sim/mm_ram_tb.sv
// testbench for mm_ram_top driven by golden operations from a data file
module mm_ram_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mm_ram_pkg::*;

    localparam int MAX_OPS        = 64;
    localparam int TIMEOUT_CYCLES = 50;

    logic         clk_i;
    logic         rst_ni;
    instr_req_t   instr_req;
    instr_rsp_t   instr_rsp;
    data_req_t    data_req;
    data_rsp_t    data_rsp;
    logic         irq_ack;
    logic [5:0]   irq_id;
    logic         irq_timer;
    host_status_t host_status;

    logic [31:0] golden [MAX_OPS*5];
    int          test_errors;
    int          pass_count;
    int          fail_count;
    bit          timed_out;

    mm_ram_top DUT (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .instr_req_i   (instr_req),
        .instr_rsp_o   (instr_rsp),
        .data_req_i    (data_req),
        .data_rsp_o    (data_rsp),
        .irq_ack_i     (irq_ack),
        .irq_id_i      (irq_id),
        .irq_timer_o   (irq_timer),
        .host_status_o (host_status)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_true(input bit ok, input string msg);
        assert (ok) else begin
            $display("FAILED %0t: %s", $time, msg);
            test_errors++;
        end
    endtask

    // issue one data request and return at the sample point of the response cycle
    task automatic data_access(input logic we, input logic [31:0] addr, input word_t wdata,
                               input be_t be, output word_t rdata);
        int cycles;
        @(posedge clk_i);
        data_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
        @(negedge clk_i);
        check_true(data_rsp.gnt === 1'b1, $sformatf("no data grant at %08h", addr));
        check_true(data_rsp.rvalid === 1'b0,
                   $sformatf("data rvalid in request cycle at %08h", addr));
        @(posedge clk_i);
        data_req <= '0;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (data_rsp.rvalid !== 1'b1 && cycles < TIMEOUT_CYCLES);
        if (data_rsp.rvalid !== 1'b1) begin
            $display("timeout: data rvalid never came for address %08h", addr);
            timed_out = 1'b1;
        end else begin
            check_true(cycles == 1, $sformatf("data rvalid after %0d cycles", cycles));
        end
        rdata = data_rsp.rdata;
    endtask

    task automatic fetch_block(input logic [31:0] addr, output instr_word_t rdata);
        int cycles;
        @(posedge clk_i);
        instr_req <= '{req: 1'b1, addr: addr};
        @(negedge clk_i);
        check_true(instr_rsp.gnt === 1'b1, $sformatf("no fetch grant at %08h", addr));
        check_true(instr_rsp.rvalid === 1'b0,
                   $sformatf("fetch rvalid in request cycle at %08h", addr));
        @(posedge clk_i);
        instr_req <= '0;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (instr_rsp.rvalid !== 1'b1 && cycles < TIMEOUT_CYCLES);
        if (instr_rsp.rvalid !== 1'b1) begin
            $display("timeout: fetch rvalid never came for address %08h", addr);
            timed_out = 1'b1;
        end else begin
            check_true(cycles == 1, $sformatf("fetch rvalid after %0d cycles", cycles));
        end
        rdata = instr_rsp.rdata;
    endtask

    task automatic send_ack(input logic [5:0] id);
        @(posedge clk_i);
        irq_ack <= 1'b1;
        irq_id  <= id;
        @(posedge clk_i);
        irq_ack <= 1'b0;
        irq_id  <= '0;
        @(negedge clk_i);
    endtask

    function automatic logic [3:0] pulse_bits();
        return {host_status.exit_valid, host_status.tests_failed,
                host_status.tests_passed, host_status.print_valid};
    endfunction

    task automatic run_op(input logic [31:0] op, input logic [31:0] addr, input word_t data,
                          input be_t be, input word_t exp);
        word_t       rdata;
        instr_word_t block;
        int          cycles;
        case (op)
            32'h0: begin
                data_access(1'b1, addr, data, be, rdata);
                check_true(rdata === '0, $sformatf("write response data %08h", rdata));
            end
            32'h1: begin
                data_access(1'b0, addr, '0, '0, rdata);
                check_true(rdata === exp, $sformatf("read %08h got %08h expected %08h",
                                                    addr, rdata, exp));
            end
            32'h2: begin
                fetch_block(addr, block);
                check_true(block[32*data[1:0] +: 32] === exp,
                           $sformatf("fetch %08h lane %0d got %08h expected %08h", addr,
                                     data[1:0], block[32*data[1:0] +: 32], exp));
            end
            32'h3: begin
                data_access(1'b1, addr, data, be, rdata);
                check_true(pulse_bits() === exp[3:0], $sformatf("pulses %04b expected %04b",
                                                                pulse_bits(), exp[3:0]));
                if (exp[0]) begin
                    check_true(host_status.print_char === data[7:0], "wrong print character");
                end
                if (exp[3]) begin
                    check_true(host_status.exit_value === data, "wrong exit value");
                end
                @(negedge clk_i);
                check_true(pulse_bits() === 4'b0000, "status pulse longer than one cycle");
            end
            32'h4: begin
                data_access(1'b1, addr, data, be, rdata);
                // count cycles from the edge that accepted the count write
                cycles = 0;
                while (irq_timer !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
                    @(negedge clk_i);
                    cycles++;
                end
                if (irq_timer !== 1'b1) begin
                    $display("timeout: timer interrupt never rose after count %0d", data);
                    timed_out = 1'b1;
                end else begin
                    check_true(cycles == int'(data), $sformatf("irq after %0d cycles", cycles));
                    repeat (2) begin
                        @(negedge clk_i);
                        check_true(irq_timer === 1'b1, "irq dropped without acknowledge");
                    end
                    send_ack(6'd3);
                    check_true(irq_timer === 1'b1, "irq cleared by acknowledge with id 3");
                    send_ack(6'(TIMER_IRQ_ID));
                    check_true(irq_timer === 1'b0, "irq not cleared by acknowledge with id 7");
                end
            end
            default: check_true(1'b0, $sformatf("unknown golden op %0h", op));
        endcase
    endtask

    initial begin
        int idx;
        bit done;
        void'($urandom(12849));
        rst_ni      = 1'b0;
        instr_req   = '0;
        data_req    = '0;
        irq_ack     = 1'b0;
        irq_id      = '0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;
        $readmemh("sim/mm_ram_golden.txt", golden);
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_true(irq_timer === 1'b0 && pulse_bits() === 4'b0000 &&
                   data_rsp.rvalid === 1'b0 && data_rsp.gnt === 1'b0 &&
                   instr_rsp.rvalid === 1'b0 && instr_rsp.gnt === 1'b0,
                   "outputs not idle after reset");
        if (test_errors == 0) begin
            pass_count++;
            $display("reset test: passed");
        end else begin
            fail_count++;
            $display("reset test: failed");
        end
        idx  = 0;
        done = 1'b0;
        while (!done && !timed_out && idx < MAX_OPS) begin
            if (golden[idx*5] === 32'hff) begin
                done = 1'b1;
            end else begin
                repeat ($urandom % 3) @(posedge clk_i);
                test_errors = 0;
                run_op(golden[idx*5], golden[idx*5+1], golden[idx*5+2],
                       be_t'(golden[idx*5+3]), golden[idx*5+4]);
                if (test_errors == 0 && !timed_out) begin
                    pass_count++;
                    $display("test %0d op %0h at %08h: passed", idx, golden[idx*5],
                             golden[idx*5+1]);
                end else begin
                    fail_count++;
                    $display("test %0d op %0h at %08h: failed", idx, golden[idx*5],
                             golden[idx*5+1]);
                end
                idx++;
            end
        end
        if (!done && !timed_out) begin
            $display("golden file has no end marker within %0d operations", MAX_OPS);
            fail_count++;
        end
        $display("tests run: %0d, passed: %0d, failed: %0d", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sim/mm_ram_golden.txt
// columns: op addr data be expected, op 0 write, 1 read, 2 fetch (data is the lane)
// op 3 peripheral write (expected pulses exit,failed,passed,print), 4 timer count, ff end
0 00000100 11223344 f 0
0 00000104 55667788 f 0
0 00000108 99aabbcc f 0
0 0000010c ddeeff00 f 0
0 00000010 01020304 f 0
0 00000100 a5a5a5a5 5 0
1 00000100 0 0 11a533a5
0 00000104 cafef00d a 0
1 00000104 0 0 ca66f088
1 00000108 0 0 99aabbcc
2 00000108 0 0 11a533a5
2 00000104 1 0 ca66f088
2 0000010c 2 0 99aabbcc
2 00000100 3 0 ddeeff00
3 10000000 00000041 f 1
3 20000000 075bcd15 f 2
3 20000000 00000001 f 4
3 20000000 00000005 f 0
3 20000004 0000002a f 8
3 15000000 00000080 f 0
4 15000004 00000005 f 0
4 15000004 00000001 f 0
3 00010010 deadbeef f 0
1 00000010 0 0 01020304
1 30000000 0 0 00000000
ff 0 0 0 0

//--- compile.f
common/mm_ram_pkg.sv
dp_ram/dp_ram.sv
source/data_decoder.sv
source/timer_irq.sv
source/host_port.sv
source/mm_ram_top.sv
sim/mm_ram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the mm_ram testbench with Verilator, runs it and checks for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module mm_ram_tb -o mm_ram_sim; then
    echo "build failed"
    exit 1
fi

output="$(./obj_dir/mm_ram_sim)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^NO ERRORS$"; then
    exit 0
fi
exit 1
